// File: design/stall_inject_pkg.sv
package stall_inject_pkg;

  // Random values and the threshold share one width so they compare directly
  typedef logic [15:0] rnd_t;

  // One item on the flow side
  typedef logic [31:0] data_t;

  // APB byte address and data word
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // APB request from the requester, bundled so it travels as one port
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  // Register map
  // Bit 0 is enable and bit 1 selects the mixed random source
  localparam apb_addr_t addr_ctrl   = 8'h00;
  // Bits 15:0 hold the stall threshold
  localparam apb_addr_t addr_thresh = 8'h04;
  // Read-only stall count, a write of any value clears it
  localparam apb_addr_t addr_stalls = 8'h08;

  // Phase tracking for the APB slave
  typedef enum logic [1:0] {
    idle,
    setup,
    access
  } ctrl_state_e;

endpackage

// File: design/max_lfsr.sv
`timescale 1ns/10ps

module max_lfsr #(
  parameter int              WIDTH = 16,
  parameter logic [WIDTH-1:0] SEED = 1
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             enable,
  output logic             wrap,
  output logic [WIDTH-1:0] count
);

  // Tap masks for maximal-length Fibonacci sequences
  // Bit n-1 of the mask stands for tap n
  function automatic logic [31:0] taps_for(input int w);
    case (w)
      4:       taps_for = 32'h0000_000c;
      8:       taps_for = 32'h0000_00b8;
      12:      taps_for = 32'h0000_0829;
      24:      taps_for = 32'h00e1_0000;
      32:      taps_for = 32'h8020_0003;
      // Taps 16, 15, 13 and 4
      default: taps_for = 32'h0000_d008;
    endcase
  endfunction

  localparam logic [31:0] TAPS = taps_for(WIDTH);

  logic [WIDTH-1:0] count_q;
  logic [WIDTH-1:0] count_nxt;
  logic             feedback;

  // Xor of all tapped bits enters at the bottom as the register shifts left
  assign feedback  = ^(count_q & TAPS[WIDTH-1:0]);
  assign count_nxt = {count_q[WIDTH-2:0], feedback};

  // Flags the step that brings the sequence back round to its seed
  assign wrap  = enable & (count_nxt == SEED);
  assign count = count_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= SEED;
    end else if (enable) begin
      count_q <= count_nxt;
    end
  end

endmodule

// File: design/random16_wupdate.sv
`timescale 1ns/10ps

module random16_wupdate #(
  parameter stall_inject_pkg::rnd_t SEED = 16'h0001
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   update,
  input  logic                   use_mix,
  output stall_inject_pkg::rnd_t random
);

  stall_inject_pkg::rnd_t lfsr_count;
  stall_inject_pkg::rnd_t cnt_q;
  stall_inject_pkg::rnd_t mix_q;
  stall_inject_pkg::rnd_t mix0;
  stall_inject_pkg::rnd_t mix1;
  stall_inject_pkg::rnd_t mix2;
  stall_inject_pkg::rnd_t mix3;
  stall_inject_pkg::rnd_t mix4;
  stall_inject_pkg::rnd_t mix5;

  // The LFSR steps on the same strobe that advances the counter
  max_lfsr #(
    .WIDTH (16),
    .SEED  (SEED)
  ) u_max_lfsr (
    .clk    (clk),
    .rst_n  (rst_n),
    .enable (update),
    .wrap   (),
    .count  (lfsr_count)
  );

  // Shift/xor/add hash of the counter
  // All sums are 16 bits wide, so carries out of bit 15 drop away
  always_comb begin
    mix0 = cnt_q ^ (cnt_q >> 10);
    mix1 = mix0 + (mix0 << 3);
    mix2 = mix1 ^ (mix1 >> 2);
    mix3 = mix2 + (mix2 << 8);
    mix4 = mix3 ^ (mix3 >> 4);
    mix5 = mix4 ^ (mix4 >> 7);
  end

  // Counter only moves on update, the hash register follows it every cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= SEED;
      mix_q <= '0;
    end else begin
      if (update) begin
        cnt_q <= cnt_q + 16'd1;
      end
      mix_q <= mix5;
    end
  end

  // Both sources are registers, so random never changes within a cycle
  assign random = use_mix ? mix_q : lfsr_count;

endmodule

// File: design/stall_inject_ctrl.sv
`timescale 1ns/10ps

module stall_inject_ctrl (
  input  logic                        clk,
  input  logic                        rst_n,
  input  stall_inject_pkg::apb_req_t  apb_req,
  output stall_inject_pkg::apb_data_t prdata,
  input  logic                        want,
  output logic                        allow,
  output logic                        update,
  output logic                        use_mix,
  input  stall_inject_pkg::rnd_t      random
);

  stall_inject_pkg::ctrl_state_e state_q;
  stall_inject_pkg::ctrl_state_e state_nxt;

  logic                        enable_q;
  logic                        use_mix_q;
  stall_inject_pkg::rnd_t      thresh_q;
  stall_inject_pkg::apb_data_t stalls_q;

  logic                        apb_fire;
  logic                        apb_wr;
  logic                        apb_rd;
  logic                        stall;
  stall_inject_pkg::apb_data_t rd_mux;

  // The state names the phase of the previous cycle
  // So setup here means the current cycle is the access phase
  always_comb begin
    state_nxt = state_q;
    case (state_q)
      stall_inject_pkg::idle: begin
        if (apb_req.psel && !apb_req.penable) begin
          state_nxt = stall_inject_pkg::setup;
        end
      end
      stall_inject_pkg::setup: begin
        if (apb_req.psel && apb_req.penable) begin
          state_nxt = stall_inject_pkg::access;
        end else if (!apb_req.psel) begin
          state_nxt = stall_inject_pkg::idle;
        end
      end
      stall_inject_pkg::access: begin
        // Back-to-back transfers start their setup right away
        if (apb_req.psel && !apb_req.penable) begin
          state_nxt = stall_inject_pkg::setup;
        end else begin
          state_nxt = stall_inject_pkg::idle;
        end
      end
      default: state_nxt = stall_inject_pkg::idle;
    endcase
  end

  // A transfer completes in the access cycle, there are no wait states
  assign apb_fire = (state_q == stall_inject_pkg::setup) & apb_req.psel & apb_req.penable;
  assign apb_wr   = apb_fire & apb_req.pwrite;
  assign apb_rd   = apb_fire & ~apb_req.pwrite;

  // Unmapped addresses read back as zero
  always_comb begin
    case (apb_req.paddr)
      stall_inject_pkg::addr_ctrl:   rd_mux = {30'd0, use_mix_q, enable_q};
      stall_inject_pkg::addr_thresh: rd_mux = {16'd0, thresh_q};
      stall_inject_pkg::addr_stalls: rd_mux = stalls_q;
      default:                       rd_mux = '0;
    endcase
  end

  assign prdata = apb_rd ? rd_mux : '0;

  // Each decision point steps the random source and compares in the same cycle
  // With the injector off the gate is always allowed through
  assign update  = want & enable_q;
  assign stall   = update & (random < thresh_q);
  assign allow   = want & ~stall;
  assign use_mix = use_mix_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= stall_inject_pkg::idle;
      enable_q  <= 1'b0;
      use_mix_q <= 1'b0;
      thresh_q  <= '0;
      stalls_q  <= '0;
    end else begin
      state_q <= state_nxt;
      if (apb_wr && (apb_req.paddr == stall_inject_pkg::addr_ctrl)) begin
        enable_q  <= apb_req.pwdata[0];
        use_mix_q <= apb_req.pwdata[1];
      end
      if (apb_wr && (apb_req.paddr == stall_inject_pkg::addr_thresh)) begin
        thresh_q <= apb_req.pwdata[15:0];
      end
      // A clear from software wins over a stall in the same cycle
      if (apb_wr && (apb_req.paddr == stall_inject_pkg::addr_stalls)) begin
        stalls_q <= '0;
      end else if (stall && (stalls_q != '1)) begin
        stalls_q <= stalls_q + 32'd1;
      end
    end
  end

endmodule

// File: design/flow_gate.sv
`timescale 1ns/10ps

module flow_gate (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid,
  input  stall_inject_pkg::data_t in_data,
  output logic                    in_ready,
  output logic                    out_valid,
  output stall_inject_pkg::data_t out_data,
  input  logic                    out_ready,
  output logic                    want,
  input  logic                    allow
);

  logic                    full_q;
  stall_inject_pkg::data_t data_q;
  logic                    load;

  // A decision is only needed when an item waits and there is room for it
  // Room means the register is empty or its item leaves this cycle
  assign want     = in_valid & (~full_q | out_ready);
  assign in_ready = want & allow;
  assign load     = in_valid & in_ready;

  // Full flag tracks whether the output register holds an item
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (out_ready) begin
      full_q <= 1'b0;
    end
  end

  // Payload only, its content is qualified by full_q
  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= in_data;
    end
  end

  assign out_valid = full_q;
  assign out_data  = data_q;

endmodule

// File: design/stall_inject_top.sv
`timescale 1ns/10ps

module stall_inject_top #(
  parameter stall_inject_pkg::rnd_t SEED = 16'h0001
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  stall_inject_pkg::apb_req_t  apb_req,
  output stall_inject_pkg::apb_data_t prdata,
  input  logic                        in_valid,
  input  stall_inject_pkg::data_t     in_data,
  output logic                        in_ready,
  output logic                        out_valid,
  output stall_inject_pkg::data_t     out_data,
  input  logic                        out_ready
);

  logic                   want;
  logic                   allow;
  logic                   update;
  logic                   use_mix;
  stall_inject_pkg::rnd_t random;

  // Register file and the per-cycle stall decision
  stall_inject_ctrl u_stall_inject_ctrl (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .prdata  (prdata),
    .want    (want),
    .allow   (allow),
    .update  (update),
    .use_mix (use_mix),
    .random  (random)
  );

  // Random source stepped once per decision point
  random16_wupdate #(
    .SEED (SEED)
  ) u_random16_wupdate (
    .clk     (clk),
    .rst_n   (rst_n),
    .update  (update),
    .use_mix (use_mix),
    .random  (random)
  );

  // Data path between the producer and the consumer
  flow_gate u_flow_gate (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready),
    .want      (want),
    .allow     (allow)
  );

endmodule

// File: test/stall_inject_assertions.sv
`timescale 1ns/10ps

module stall_inject_assertions (
  input logic                       clk,
  input logic                       rst_n,
  input stall_inject_pkg::apb_req_t apb_req,
  input logic                       in_valid,
  input stall_inject_pkg::data_t    in_data,
  input logic                       in_ready,
  input logic                       out_valid,
  input stall_inject_pkg::data_t    out_data,
  input logic                       out_ready,
  input logic                       want,
  input logic                       allow,
  input logic                       update
);

  // A producer that is not accepted must hold its item unchanged
  a_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && !in_ready |=> in_valid && $stable(in_data))
    else $error("input item dropped or changed before acceptance");

  // The output register keeps its item until the consumer takes it
  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else $error("output item dropped or changed before acceptance");

  // The random source only steps at a decision point
  a_update_want: assert property (@(posedge clk) disable iff (!rst_n) update |-> want)
    else $error("update raised without a decision point");

  a_allow_want: assert property (@(posedge clk) disable iff (!rst_n) allow |-> want)
    else $error("allow raised without a decision point");

  // A setup phase is always followed by its access phase
  a_apb_phase: assert property (@(posedge clk) disable iff (!rst_n)
    apb_req.psel && !apb_req.penable |=> apb_req.psel && apb_req.penable)
    else $error("APB setup phase not followed by access phase");

endmodule

// Attached at the top level, where the gate and control signals meet
bind stall_inject_top stall_inject_assertions u_stall_inject_assertions (
  .clk       (clk),
  .rst_n     (rst_n),
  .apb_req   (apb_req),
  .in_valid  (in_valid),
  .in_data   (in_data),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_data  (out_data),
  .out_ready (out_ready),
  .want      (want),
  .allow     (allow),
  .update    (update)
);

// File: test/stall_inject_tb.sv
`timescale 1ns/10ps

module stall_inject_tb;

  localparam stall_inject_pkg::rnd_t SEED = 16'h0001;

  logic                        clk;
  logic                        rst_n;
  stall_inject_pkg::apb_req_t  apb_req;
  stall_inject_pkg::apb_data_t prdata;
  logic                        in_valid;
  stall_inject_pkg::data_t     in_data;
  logic                        in_ready;
  logic                        out_valid;
  stall_inject_pkg::data_t     out_data;
  logic                        out_ready;

  // Test table read from the stim file
  int t_mode[$];
  int t_thresh[$];
  int t_items[$];
  int t_bp[$];
  int t_expect[$];

  int cycles = 0;
  int cycle_limit = 2000;

  // Reference model state, advanced at every falling edge
  logic [15:0] m_lfsr;
  logic [15:0] m_cnt;
  logic [15:0] m_mix;
  logic [15:0] m_rnd;
  logic        m_en = 1'b0;
  logic        m_mix_sel = 1'b0;
  logic [15:0] m_thresh = '0;
  logic        m_want;
  logic        m_stall;
  logic        exp_ready;
  int          model_stalls = 0;

  // Scoreboard state for the output side
  logic    prev_acc = 1'b0;
  logic [31:0] prev_data;
  logic [31:0] exp_out = '0;
  logic [31:0] tx_data = '0;
  int          rx_count = 0;

  stall_inject_top #(
    .SEED (SEED)
  ) u_stall_inject_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .apb_req   (apb_req),
    .prdata    (prdata),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic report_error(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // Fibonacci step with taps 16, 15, 13 and 4
  function automatic logic [15:0] lfsr_step(input logic [15:0] v);
    return {v[14:0], v[15] ^ v[14] ^ v[12] ^ v[3]};
  endfunction

  // Six-step shift/xor/add hash, all sums wrap at 16 bits
  function automatic logic [15:0] mix_hash(input logic [15:0] c);
    logic [15:0] h;
    h = c ^ (c >> 10);
    h = h + (h << 3);
    h = h ^ (h >> 2);
    h = h + (h << 8);
    h = h ^ (h >> 4);
    h = h ^ (h >> 7);
    return h;
  endfunction

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: the run went past %0d clock cycles without finishing", cycle_limit);
      $display("CHECKS FAILED");
      $fatal(1, "timeout");
    end
  end

  // Model sees the same port conditions as the gate and predicts in_ready
  always @(negedge clk) begin
    if (!rst_n) begin
      m_lfsr = SEED;
      m_cnt  = SEED;
      m_mix  = '0;
    end else begin
      m_want    = in_valid && (!out_valid || out_ready);
      m_rnd     = m_mix_sel ? m_mix : m_lfsr;
      m_stall   = m_en && m_want && (m_rnd < m_thresh);
      exp_ready = m_want && !m_stall;
      assert (in_ready === exp_ready)
        else report_error($sformatf("in_ready %b, model expects %b", in_ready, exp_ready));
      if (m_stall) model_stalls++;
      // The hash register follows the counter one cycle behind
      m_mix = mix_hash(m_cnt);
      if (m_en && m_want) begin
        m_cnt  = m_cnt + 16'd1;
        m_lfsr = lfsr_step(m_lfsr);
      end
    end
  end

  // Latency and ordering checks on the output port
  always @(negedge clk) begin
    if (rst_n) begin
      if (prev_acc) begin
        assert (out_valid && out_data == prev_data)
          else report_error($sformatf("item %h not at output one cycle after acceptance",
                                      prev_data));
      end
      if (out_valid && out_ready) begin
        assert (out_data == exp_out)
          else report_error($sformatf("out_data %h, expected %h", out_data, exp_out));
        exp_out++;
        rx_count++;
      end
      prev_acc  = in_valid && in_ready;
      prev_data = in_data;
    end
  end

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    #2;
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(posedge clk);
    #2;
    apb_req.penable = 1'b1;
    @(posedge clk);
    #2;
    apb_req = '0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk);
    #2;
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
    @(posedge clk);
    #2;
    apb_req.penable = 1'b1;
    @(negedge clk);
    data = prdata;
    @(posedge clk);
    #2;
    apb_req = '0;
  endtask

  task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    apb_read(addr, got);
    assert (got == exp)
      else report_error($sformatf("read of %h gave %h, expected %h", addr, got, exp));
  endtask

  task automatic produce(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      #2;
      in_valid = 1'b1;
      in_data  = tx_data;
      @(negedge clk);
      while (!in_ready) @(negedge clk);
      tx_data++;
    end
    @(posedge clk);
    #2;
    in_valid = 1'b0;
  endtask

  // Consumer drops out_ready with the given percentage
  task automatic consume(input int n, input int bp);
    while (rx_count < n) begin
      @(posedge clk);
      #2;
      out_ready = ($urandom % 100) >= bp;
    end
    out_ready = 1'b1;
  endtask

  task automatic run_test(input int k);
    logic [31:0] got;
    // Bit 1 selects the hash, bit 0 enables the injector
    apb_write(stall_inject_pkg::addr_ctrl, {30'd0, t_mode[k] == 2, t_mode[k] != 0});
    m_en      = (t_mode[k] != 0);
    m_mix_sel = (t_mode[k] == 2);
    apb_write(stall_inject_pkg::addr_thresh, t_thresh[k]);
    m_thresh = t_thresh[k][15:0];
    apb_write(stall_inject_pkg::addr_stalls, 32'hffff_ffff);
    model_stalls = 0;
    read_expect(stall_inject_pkg::addr_stalls, 32'd0);
    rx_count = 0;
    fork
      produce(t_items[k]);
      consume(t_items[k], t_bp[k]);
    join
    apb_read(stall_inject_pkg::addr_stalls, got);
    assert (got == model_stalls)
      else report_error($sformatf("test %0d stalls %0d, model %0d", k, got, model_stalls));
    // Negative entries leave the count to the model alone
    if (t_expect[k] >= 0) begin
      assert (got == t_expect[k])
        else report_error($sformatf("test %0d stalls %0d, stim file %0d", k, got, t_expect[k]));
    end
  endtask

  initial begin
    int    fd;
    int    total;
    int    a, b, c, d, e;
    string line;
    void'($urandom(32'hdb9c));
    rst_n     = 1'b0;
    apb_req   = '0;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b1;
    fd = $fopen("test/stall_inject_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file test/stall_inject_stim.txt");
      $display("CHECKS FAILED");
      $fatal(1, "no stimulus");
    end
    total = 0;
    while (!$feof(fd)) begin
      void'($fgets(line, fd));
      if ($sscanf(line, "%d %h %d %d %d", a, b, c, d, e) == 5) begin
        t_mode.push_back(a);
        t_thresh.push_back(b);
        t_items.push_back(c);
        t_bp.push_back(d);
        t_expect.push_back(e);
        total += c;
      end
    end
    $fclose(fd);
    cycle_limit = 20 * total + 2000;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // Register reset values, read back and unmapped reads
    read_expect(stall_inject_pkg::addr_ctrl, 32'd0);
    read_expect(stall_inject_pkg::addr_thresh, 32'd0);
    read_expect(stall_inject_pkg::addr_stalls, 32'd0);
    read_expect(8'h0c, 32'd0);
    apb_write(stall_inject_pkg::addr_ctrl, 32'h0000_0002);
    read_expect(stall_inject_pkg::addr_ctrl, 32'd2);
    apb_write(stall_inject_pkg::addr_thresh, 32'h0001_beef);
    read_expect(stall_inject_pkg::addr_thresh, 32'h0000_beef);
    apb_write(stall_inject_pkg::addr_ctrl, 32'd0);
    apb_write(stall_inject_pkg::addr_thresh, 32'd0);
    for (int k = 0; k < t_mode.size(); k++) begin
      run_test(k);
    end
    // Every item listed in the table went in and came out again
    if ((exp_out == tx_data) && (tx_data == total)) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      $display("Item count wrong: %0d sent, %0d received, %0d listed in the table",
               tx_data, exp_out, total);
      $display("CHECKS FAILED");
      $fatal(1, "item count mismatch");
    end
  end

endmodule

// File: test/stall_inject_stim.txt
# mode (0 off, 1 LFSR, 2 mix)  threshold (hex)  items  sink back-pressure %  expected stalls
# An expected count of -1 leaves the count to the reference model
0 0000 40 0 0
0 8000 60 0 0
0 ffff 50 0 0
1 0000 60 0 0
2 0000 60 0 0
0 4000 80 30 0
1 0000 80 40 0
1 1000 100 0 -1
1 2000 100 0 -1
1 4000 120 0 -1
1 8000 120 0 -1
1 c000 80 0 -1
1 e000 60 0 -1
1 0100 100 0 -1
1 f000 50 0 -1
2 1000 100 0 -1
2 2000 100 0 -1
2 4000 120 0 -1
2 8000 120 0 -1
2 c000 80 0 -1
2 e000 60 0 -1
2 0100 100 0 -1
2 f000 50 0 -1
1 4000 100 20 -1
1 8000 100 50 -1
1 2000 100 70 -1
2 4000 100 20 -1
2 8000 100 50 -1
2 2000 100 70 -1
0 0000 100 60 0
1 6000 80 10 -1
2 6000 80 10 -1
1 a000 80 35 -1
2 a000 80 35 -1
1 3000 60 45 -1
2 3000 60 45 -1
1 0001 80 0 -1
2 0001 80 0 -1
1 7fff 90 25 -1
2 7fff 90 25 -1
0 7fff 90 25 0
1 5000 70 55 -1
2 5000 70 55 -1
1 9000 70 15 -1
2 9000 70 15 -1
1 d000 40 5 -1
2 d000 40 5 -1
0 0000 50 0 0

// File: verilog.f
design/stall_inject_pkg.sv
design/max_lfsr.sv
design/random16_wupdate.sv
design/stall_inject_ctrl.sv
design/flow_gate.sv
design/stall_inject_top.sv
test/stall_inject_assertions.sv
test/stall_inject_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= stall_inject_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
	  --Mdir $(OBJ_DIR) -o V$(TOP)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
